//--- apuRegPkg.sv
/* Register map of the APU: bus request and channel write structs,
   address groups and control register field positions */
package apuRegPkg;

  // 5-bit register address, $4000-$4017 seen from the APU side
  typedef logic [4:0] addrT;

  // One CPU bus cycle towards the APU
  typedef struct packed {
    logic       wr;    // Write strobe
    logic       rd;    // Read strobe
    addrT       addr;
    logic [7:0] data;
  } busReqT;

  // One register write as a channel sees it
  typedef struct packed {
    logic       wr;
    logic [1:0] offset;  // Register within the channel group
    logic [7:0] data;
  } chanWriteT;

  // ------------------------------
  // Upper address bits per group
  localparam logic [2:0] sq1Group  = 3'd0;
  localparam logic [2:0] sq2Group  = 3'd1;
  localparam logic [2:0] triGroup  = 3'd2;
  localparam logic [2:0] ctrlGroup = 3'd5;

  localparam addrT statusAddr    = 5'h15;  // Enable write, status read
  localparam addrT frameCtrlAddr = 5'h17;  // Frame counter control

  // ------------------------------
  // Field positions in $17 and in the status byte
  localparam int frameModeBit  = 7;  // 1 selects the 5-step sequence
  localparam int irqInhibitBit = 6;
  localparam int statusIrqBit  = 6;

endpackage

//--- apuAudioPkg.sv
/* Audio side of the APU: sample types, frame tick struct,
   frame sequencer step counts and mixer weights */
package apuAudioPkg;

  typedef logic [3:0]  pulseSampleT;  // Pulse or triangle output level
  typedef logic [15:0] mixSampleT;
  typedef logic [7:0]  lenCountT;

  // Frame sequencer clocks towards the channels
  typedef struct packed {
    logic quarter;  // Envelope and linear counter
    logic half;     // Length counter and sweep
  } frameTickT;

  // ------------------------------
  // Step counts, in ce cycles from the start of a frame
  localparam logic [15:0] quarterStep1 = 16'd7457;
  localparam logic [15:0] halfStep2    = 16'd14913;
  localparam logic [15:0] quarterStep3 = 16'd22371;
  localparam logic [15:0] fourStepEnd  = 16'd29829;
  localparam logic [15:0] fiveStepEnd  = 16'd37281;

  // Linear mixer
  localparam logic [3:0] pulseWeight = 4'd1;
  localparam logic [3:0] triWeight   = 4'd2;

  // Bits in the channel mask and enable vectors
  localparam int sq1Bit = 0;
  localparam int sq2Bit = 1;
  localparam int triBit = 2;

endpackage

//--- lengthCounter.sv
/* Length counter with its 32-entry length table */
`timescale 1ns/10ps

module lengthCounter (
  input  logic       clk,
  input  logic       reset,
  input  logic       ce,
  input  logic       load,       // Offset-3 write to the owning channel
  input  logic [4:0] loadIndex,
  input  logic       halt,
  input  logic       tickHalf,
  input  logic       enable,
  output logic       nonZero
);

  // Lengths are stored already doubled
  localparam apuAudioPkg::lenCountT lenTable [0:31] = '{
    8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
    8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
    8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
    8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
  };

  apuAudioPkg::lenCountT count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (ce) begin
      if (!enable) begin
        count <= '0;  // Disabled channel is silenced at once
      end else if (load) begin
        count <= lenTable[loadIndex];
      end else if (tickHalf && count != 0 && !halt) begin
        count <= count - 1'b1;
      end
    end
  end

  assign nonZero = (count != 0);

endmodule

//--- envelopeUnit.sv
/* Envelope generator of a pulse channel: divider, decay level and
   constant-volume select */
`timescale 1ns/10ps

module envelopeUnit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ce,
  input  apuRegPkg::chanWriteT    wr,
  input  logic                    tickQuarter,
  output apuAudioPkg::pulseSampleT level
);

  logic       loopEnv;
  logic       constVol;
  logic [3:0] volume;    // Also the divider period
  logic [3:0] divider;
  logic [3:0] decay;
  logic       startFlag;

  always_ff @(posedge clk) begin
    if (reset) begin
      loopEnv   <= 1'b0;
      constVol  <= 1'b0;
      volume    <= '0;
      divider   <= '0;
      decay     <= '0;
      startFlag <= 1'b0;
    end else if (ce) begin
      if (tickQuarter) begin
        if (startFlag) begin
          startFlag <= 1'b0;
          divider   <= volume;
          decay     <= 4'd15;
        end else if (divider == 0) begin
          divider <= volume;
          if (decay != 0 || loopEnv)
            decay <= decay - 1'b1;  // Wraps 0 -> 15 when looping
        end else begin
          divider <= divider - 1'b1;
        end
      end
      // A write in the same cycle as a tick takes effect after it
      if (wr.wr && wr.offset == 2'd0) begin
        loopEnv  <= wr.data[5];
        constVol <= wr.data[4];
        volume   <= wr.data[3:0];
      end
      if (wr.wr && wr.offset == 2'd3)
        startFlag <= 1'b1;
    end
  end

  assign level = constVol ? volume : decay;

endmodule

//--- squareChannel.sv
/* Pulse channel with period timer, duty sequencer, sweep unit and output
   gating, plus its envelope and length counter */
`timescale 1ns/10ps

module squareChannel #(
  parameter bit sweepCarry = 1'b0  // 1 gives the two's-complement negate
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     ce,
  input  apuRegPkg::chanWriteT     wr,
  input  apuAudioPkg::frameTickT   tick,
  input  logic                     enable,
  output apuAudioPkg::pulseSampleT sample,
  output logic                     nonZero
);

  logic [1:0]  duty;
  logic        lenHalt;      // Shares bit 5 with the envelope loop
  logic        sweepEnable;
  logic        sweepNegate;
  logic        sweepReload;
  logic [2:0]  sweepPeriod;
  logic [2:0]  sweepDivider;
  logic [2:0]  sweepShift;
  logic [10:0] period;
  logic [11:0] timer;
  logic [2:0]  seqPos;
  logic        dutyHigh;

  apuAudioPkg::pulseSampleT envLevel;

  // ------------------------------
  // Sweep adder and frequency check
  logic [10:0] shifted;
  logic [10:0] sweepRhs;
  logic [11:0] sweepTarget;
  logic        validFreq;

  assign shifted     = period >> sweepShift;
  assign sweepRhs    = sweepNegate ? (~shifted + {10'b0, sweepCarry}) : shifted;
  assign sweepTarget = {1'b0, period} + {1'b0, sweepRhs};
  // Periods below 8 are muted
  assign validFreq   = (period[10:3] != 8'd0) && (sweepNegate || !sweepTarget[11]);

  always_ff @(posedge clk) begin
    if (reset) begin
      duty         <= '0;
      lenHalt      <= 1'b0;
      sweepEnable  <= 1'b0;
      sweepNegate  <= 1'b0;
      sweepReload  <= 1'b0;
      sweepPeriod  <= '0;
      sweepDivider <= '0;
      sweepShift   <= '0;
      period       <= '0;
      timer        <= '0;
      seqPos       <= '0;
    end else if (ce) begin
      if (wr.wr) begin
        case (wr.offset)
          2'd0: begin
            duty    <= wr.data[7:6];
            lenHalt <= wr.data[5];
          end
          2'd1: begin
            sweepEnable <= wr.data[7];
            sweepPeriod <= wr.data[6:4];
            sweepNegate <= wr.data[3];
            sweepShift  <= wr.data[2:0];
            sweepReload <= 1'b1;
          end
          2'd2: period[7:0] <= wr.data;
          default: begin
            period[10:8] <= wr.data[2:0];
            seqPos       <= '0;  // Restart the duty cycle
          end
        endcase
      end

      // Timer runs at half the CPU rate so the reload is doubled
      if (timer == 0) begin
        timer  <= {period, 1'b0};
        seqPos <= seqPos - 1'b1;
      end else begin
        timer <= timer - 1'b1;
      end

      if (tick.half) begin
        if (sweepDivider == 0) begin
          sweepDivider <= sweepPeriod;
          if (sweepEnable && sweepShift != 0 && validFreq)
            period <= sweepTarget[10:0];
        end else begin
          sweepDivider <= sweepDivider - 1'b1;
        end
        if (sweepReload)
          sweepDivider <= sweepPeriod;
        sweepReload <= 1'b0;
      end
    end
  end

  always_comb begin
    case (duty)
      2'd0:    dutyHigh = (seqPos == 3'd7);  // 12.5%
      2'd1:    dutyHigh = (seqPos >= 3'd6);  // 25%
      2'd2:    dutyHigh = (seqPos >= 3'd4);  // 50%
      default: dutyHigh = (seqPos < 3'd6);   // 75%
    endcase
  end

  assign sample = (nonZero && validFreq && dutyHigh) ? envLevel : '0;

  envelopeUnit u_envelopeUnit (
    .clk        (clk),
    .reset      (reset),
    .ce         (ce),
    .wr         (wr),
    .tickQuarter(tick.quarter),
    .level      (envLevel)
  );

  lengthCounter u_lengthCounter (
    .clk      (clk),
    .reset    (reset),
    .ce       (ce),
    .load     (wr.wr && wr.offset == 2'd3),
    .loadIndex(wr.data[7:3]),
    .halt     (lenHalt),
    .tickHalf (tick.half),
    .enable   (enable),
    .nonZero  (nonZero)
  );

endmodule

//--- triangleChannel.sv
/* Triangle channel: linear counter, period timer and 32-step ramp
   sequencer, with its length counter */
`timescale 1ns/10ps

module triangleChannel (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     ce,
  input  apuRegPkg::chanWriteT     wr,
  input  apuAudioPkg::frameTickT   tick,
  input  logic                     enable,
  output apuAudioPkg::pulseSampleT sample,
  output logic                     nonZero
);

  logic [10:0] period;
  logic [10:0] timer;
  logic [4:0]  seqPos;
  logic        linCtrl;     // Control flag, also halts the length counter
  logic        linReload;   // Reload flag set by an offset-3 write
  logic [6:0]  linPeriod;
  logic [6:0]  linCount;

  always_ff @(posedge clk) begin
    if (reset) begin
      period    <= '0;
      timer     <= '0;
      seqPos    <= '0;
      linCtrl   <= 1'b0;
      linReload <= 1'b0;
      linPeriod <= '0;
      linCount  <= '0;
    end else if (ce) begin
      if (wr.wr) begin
        case (wr.offset)
          2'd0: begin
            linCtrl   <= wr.data[7];
            linPeriod <= wr.data[6:0];
          end
          2'd2: period[7:0] <= wr.data;
          2'd3: begin
            period[10:8] <= wr.data[2:0];
            linReload    <= 1'b1;
          end
          default: ;  // Offset 1 is unused on this channel
        endcase
      end

      if (timer == 0)
        timer <= period;
      else
        timer <= timer - 1'b1;

      if (tick.quarter) begin
        if (linReload)
          linCount <= linPeriod;
        else if (linCount != 0)
          linCount <= linCount - 1'b1;
        if (!linCtrl)
          linReload <= 1'b0;
      end

      // Ramp holds its level while either counter is empty
      if (timer == 0 && nonZero && linCount != 0)
        seqPos <= seqPos + 1'b1;
    end
  end

  // 15 down to 0, then 0 up to 15
  assign sample = seqPos[3:0] ^ {4{~seqPos[4]}};

  lengthCounter u_lengthCounter (
    .clk      (clk),
    .reset    (reset),
    .ce       (ce),
    .load     (wr.wr && wr.offset == 2'd3),
    .loadIndex(wr.data[7:3]),
    .halt     (linCtrl),
    .tickHalf (tick.half),
    .enable   (enable),
    .nonZero  (nonZero)
  );

endmodule

//--- frameSequencer.sv
/* Frame sequencer: step counter, 4/5-step mode, odd/even clock and
   the frame interrupt */
`timescale 1ns/10ps

module frameSequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ce,
  input  apuRegPkg::busReqT      bus,
  input  logic                   frameCtrlWr,  // Write to $17
  output apuAudioPkg::frameTickT tick,
  output logic                   frameIrq,
  output logic                   irq,
  output logic                   oddCycle
);

  logic        fiveStep;
  logic        inhibit;
  logic        wroteLate;   // $17 write landed on an odd cycle
  logic [15:0] stepCount;
  logic        statusRead;
  logic        setIrq;
  logic        clearIrq;

  assign statusRead = bus.rd && bus.addr == apuRegPkg::statusAddr;
  assign setIrq     = stepCount == apuAudioPkg::fourStepEnd && !fiveStep && !inhibit;
  assign clearIrq   = statusRead ||
                      (frameCtrlWr && bus.data[apuRegPkg::irqInhibitBit]);

  always_ff @(posedge clk) begin
    if (reset) begin
      fiveStep  <= 1'b0;
      inhibit   <= 1'b0;
      wroteLate <= 1'b0;
      stepCount <= 16'd4;
      tick      <= '0;
      frameIrq  <= 1'b0;
      oddCycle  <= 1'b0;
    end else if (ce) begin
      oddCycle  <= !oddCycle;
      stepCount <= stepCount + 1'b1;
      tick      <= '0;

      // Setting wins over a clear in the same cycle
      if (setIrq)
        frameIrq <= 1'b1;
      else if (clearIrq)
        frameIrq <= 1'b0;

      // ------------------------------
      // Step decode
      case (stepCount)
        apuAudioPkg::quarterStep1: tick.quarter <= 1'b1;
        apuAudioPkg::halfStep2:    tick <= '{quarter: 1'b1, half: 1'b1};
        apuAudioPkg::quarterStep3: tick.quarter <= 1'b1;
        apuAudioPkg::fourStepEnd: begin
          if (!fiveStep) begin
            tick      <= '{quarter: 1'b1, half: 1'b1};
            stepCount <= '0;
          end
        end
        apuAudioPkg::fiveStepEnd: begin
          tick      <= '{quarter: 1'b1, half: 1'b1};
          stepCount <= '0;
        end
        default: ;
      endcase

      wroteLate <= 1'b0;
      if (wroteLate) begin
        if (fiveStep)
          tick <= '{quarter: 1'b1, half: 1'b1};
        stepCount <= '0;
      end

      // ------------------------------
      // $17 write, immediate on even cycles
      if (frameCtrlWr) begin
        fiveStep  <= bus.data[apuRegPkg::frameModeBit];
        inhibit   <= bus.data[apuRegPkg::irqInhibitBit];
        wroteLate <= oddCycle;
        if (!oddCycle) begin
          if (bus.data[apuRegPkg::frameModeBit])
            tick <= '{quarter: 1'b1, half: 1'b1};
          stepCount <= '0;
        end
      end
    end
  end

  assign irq = frameIrq;  // Only interrupt source left

endmodule

//--- apuStatus.sv
/* Write decode into channel strobes, $15 enable register and the
   status byte */
`timescale 1ns/10ps

module apuStatus (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ce,
  input  apuRegPkg::busReqT    bus,
  input  logic [2:0]           chanNonZero,
  input  logic                 frameIrq,
  output apuRegPkg::chanWriteT sq1Wr,
  output apuRegPkg::chanWriteT sq2Wr,
  output apuRegPkg::chanWriteT triWr,
  output logic                 frameCtrlWr,
  output logic [2:0]           enables,
  output logic [7:0]           dout
);

  logic ctrlWr;
  logic enableWr;

  // Strobe for one channel group, offset kept as the low address bits
  function automatic apuRegPkg::chanWriteT groupWrite(
    input apuRegPkg::busReqT req,
    input logic [2:0]        group
  );
    groupWrite.wr     = req.wr && req.addr[4:2] == group;
    groupWrite.offset = req.addr[1:0];
    groupWrite.data   = req.data;
  endfunction

  assign sq1Wr = groupWrite(bus, apuRegPkg::sq1Group);
  assign sq2Wr = groupWrite(bus, apuRegPkg::sq2Group);
  assign triWr = groupWrite(bus, apuRegPkg::triGroup);

  assign ctrlWr      = bus.wr && bus.addr[4:2] == apuRegPkg::ctrlGroup;
  assign enableWr    = ctrlWr && bus.addr[1:0] == apuRegPkg::statusAddr[1:0];
  assign frameCtrlWr = ctrlWr && bus.addr[1:0] == apuRegPkg::frameCtrlAddr[1:0];

  always_ff @(posedge clk) begin
    if (reset)
      enables <= '0;
    else if (ce && enableWr)
      enables <= bus.data[2:0];
  end

  // Bits 3, 4 and 7 belong to removed channels
  always_comb begin
    dout = '0;
    dout[2:0] = chanNonZero;
    dout[apuRegPkg::statusIrqBit] = frameIrq;
  end

endmodule

//--- audioMixer.sv
/* Masked linear mixer with a registered output */
`timescale 1ns/10ps

module audioMixer (
  input  logic                     clk,
  input  logic                     reset,
  input  apuAudioPkg::pulseSampleT sq1,
  input  apuAudioPkg::pulseSampleT sq2,
  input  apuAudioPkg::pulseSampleT triangle,
  input  logic [2:0]               chanMask,
  output apuAudioPkg::mixSampleT   sample
);

  apuAudioPkg::mixSampleT pulseSum;
  apuAudioPkg::mixSampleT triPart;

  assign pulseSum = (chanMask[apuAudioPkg::sq1Bit] ? 16'(sq1) : 16'd0) +
                    (chanMask[apuAudioPkg::sq2Bit] ? 16'(sq2) : 16'd0);
  assign triPart  = chanMask[apuAudioPkg::triBit] ? 16'(triangle) : 16'd0;

  always_ff @(posedge clk) begin
    if (reset)
      sample <= '0;
    else
      sample <= 16'(apuAudioPkg::pulseWeight) * pulseSum +
                16'(apuAudioPkg::triWeight) * triPart;
  end

endmodule

//--- apuTop.sv
/* APU top level: bus decode, frame sequencer, two pulse channels,
   triangle channel and mixer */
`timescale 1ns/10ps

module apuTop (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ce,
  input  apuRegPkg::busReqT      bus,
  input  logic [2:0]             chanMask,
  output logic [7:0]             dout,
  output logic                   irq,
  output logic                   oddCycle,
  output apuAudioPkg::mixSampleT sample
);

  apuRegPkg::chanWriteT     sq1Wr, sq2Wr, triWr;
  apuAudioPkg::frameTickT   tick;
  apuAudioPkg::pulseSampleT sq1Sample, sq2Sample, triSample;
  logic                     frameCtrlWr;
  logic                     frameIrq;
  logic [2:0]               enables;
  logic [2:0]               chanNonZero;  // Indexed like the mask

  apuStatus u_apuStatus (
    .clk(clk), .reset(reset), .ce(ce), .bus(bus),
    .chanNonZero(chanNonZero), .frameIrq(frameIrq),
    .sq1Wr(sq1Wr), .sq2Wr(sq2Wr), .triWr(triWr),
    .frameCtrlWr(frameCtrlWr), .enables(enables), .dout(dout)
  );

  frameSequencer u_frameSequencer (
    .clk(clk), .reset(reset), .ce(ce), .bus(bus), .frameCtrlWr(frameCtrlWr),
    .tick(tick), .frameIrq(frameIrq), .irq(irq), .oddCycle(oddCycle)
  );

  // Pulse 1 negates with one's complement, pulse 2 with two's complement
  squareChannel #(.sweepCarry(1'b0)) u_sq1 (
    .clk(clk), .reset(reset), .ce(ce), .wr(sq1Wr), .tick(tick),
    .enable(enables[apuAudioPkg::sq1Bit]), .sample(sq1Sample),
    .nonZero(chanNonZero[apuAudioPkg::sq1Bit])
  );

  squareChannel #(.sweepCarry(1'b1)) u_sq2 (
    .clk(clk), .reset(reset), .ce(ce), .wr(sq2Wr), .tick(tick),
    .enable(enables[apuAudioPkg::sq2Bit]), .sample(sq2Sample),
    .nonZero(chanNonZero[apuAudioPkg::sq2Bit])
  );

  triangleChannel u_tri (
    .clk(clk), .reset(reset), .ce(ce), .wr(triWr), .tick(tick),
    .enable(enables[apuAudioPkg::triBit]), .sample(triSample),
    .nonZero(chanNonZero[apuAudioPkg::triBit])
  );

  audioMixer u_audioMixer (
    .clk(clk), .reset(reset), .sq1(sq1Sample), .sq2(sq2Sample),
    .triangle(triSample), .chanMask(chanMask), .sample(sample)
  );

endmodule

//--- tbClock.sv
/* Testbench clock and reset generator */
`timescale 1ns/10ps

module tbClock #(
  parameter int halfPeriod  = 2,  // ns, 4 ns clock
  parameter int resetCycles = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  // Released on a falling edge, away from the DUT sampling edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- apuTb.sv
/* APU testbench with the stimulus file reader, compare tasks, cycle
   watchdog and per-test report */
`timescale 1ns/10ps

module apuTb;

  localparam int maxRecords = 64;
  localparam int numTests   = 6;

  logic                   clk;
  logic                   reset;
  logic                   ce;
  apuRegPkg::busReqT      bus;
  logic [2:0]             chanMask;
  logic [7:0]             dout;
  logic                   irq;
  logic                   oddCycle;
  apuAudioPkg::mixSampleT sample;

  // op[51:48] addr[47:40] data[39:32] count[31:16] expected[15:0]
  logic [51:0] stimMem [0:maxRecords-1];

  int limit       = 0;
  int cycles      = 0;
  int curTest     = 0;
  int testErrors  = 0;
  int totalErrors = 0;
  int testsPassed = 0;
  int testsFailed = 0;

  tbClock u_tbClock (.clk(clk), .reset(reset));

  apuTop u_apuTop (
    .clk(clk), .reset(reset), .ce(ce), .bus(bus), .chanMask(chanMask),
    .dout(dout), .irq(irq), .oddCycle(oddCycle), .sample(sample)
  );

  function automatic string testName(input int idx);
    case (idx)
      0:       return "reset state";
      1:       return "length status";
      2:       return "frame irq";
      3:       return "five-step length";
      4:       return "pulse window";
      5:       return "triangle levels";
      default: return "outside any test";
    endcase
  endfunction

  task automatic noteError();
    testErrors++;
    totalErrors++;
  endtask

  // ------------------------------
  // Compare tasks
  task automatic checkStatus(input logic [7:0] expected, input logic [7:0] actual);
    if (actual !== expected) begin
      $display("** Error [%s] status byte: expected 0x%02h, actual 0x%02h",
               testName(curTest), expected, actual);
      noteError();
    end
  endtask

  task automatic checkIrq(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error [%s] irq: expected %b, actual %b",
               testName(curTest), expected, actual);
      noteError();
    end
  endtask

  task automatic checkOddCycle(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error [%s] oddCycle: expected %b, actual %b",
               testName(curTest), expected, actual);
      noteError();
    end
  endtask

  task automatic checkSample(input string what, input apuAudioPkg::mixSampleT expected,
                             input apuAudioPkg::mixSampleT actual);
    if (actual !== expected) begin
      $display("** Error [%s] sample %s: expected %0d, actual %0d",
               testName(curTest), what, expected, actual);
      noteError();
    end
  endtask

  // ------------------------------
  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the run went past its limit of %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    logic [3:0]             op;
    logic [7:0]             addr;
    logic [7:0]             data;
    logic [15:0]            count;
    logic [15:0]            expected;
    apuAudioPkg::mixSampleT winMax;
    apuAudioPkg::mixSampleT winMin;
    logic [15:0]            seen;
    int                     n;
    int                     waitSum;
    bit                     running;

    bus      = '0;
    ce       = 1'b0;
    chanMask = '0;
    $readmemh("apuStimulus.mem", stimMem);

    // Limit covers every counted cycle plus one per record and a 10% margin
    n       = 0;
    waitSum = 0;
    while (n < maxRecords && stimMem[n][51:48] != 4'h0) begin
      waitSum += int'(stimMem[n][31:16]) + 1;
      n++;
    end
    limit = waitSum + waitSum / 10;

    @(negedge reset);
    n       = 0;
    running = 1'b1;
    while (running && n < maxRecords) begin
      {op, addr, data, count, expected} = stimMem[n];
      n++;
      case (op)
        4'h0: running = 1'b0;
        4'h1: begin  // Register write
          bus.wr   = 1'b1;
          bus.addr = addr[4:0];
          bus.data = data;
          @(negedge clk);
          bus = '0;
        end
        4'h2: begin  // Status read sees the old value during the strobe
          checkStatus(expected[7:0], dout);
          bus.rd   = 1'b1;
          bus.addr = addr[4:0];
          @(negedge clk);
          bus = '0;
        end
        4'h3: begin
          checkIrq(expected[0], irq);
          @(negedge clk);
        end
        4'h4: begin  // Min and max over a window
          winMax = '0;
          winMin = '1;
          repeat (count) begin
            if (sample > winMax) winMax = sample;
            if (sample < winMin) winMin = sample;
            @(negedge clk);
          end
          checkSample("maximum", expected, winMax);
          checkSample("minimum", apuAudioPkg::mixSampleT'(data), winMin);
        end
        4'h5: begin  // Triangle levels seen over a window
          seen = '0;
          repeat (count) begin
            for (int k = 0; k < 16; k++)
              if (sample == 16'(apuAudioPkg::triWeight) * 16'(k))
                seen[k] = 1'b1;
            @(negedge clk);
          end
          for (int k = 0; k < 16; k++) begin
            if (expected[k] && !seen[k]) begin
              $display("Test %s: level %0d never appeared in the sample window",
                       testName(curTest), k);
              noteError();
            end
          end
        end
        4'h6: repeat (count) @(negedge clk);
        4'h7: begin
          ce       = data[7];
          chanMask = data[2:0];
          @(negedge clk);
        end
        4'h8: begin
          $display("Test %0d %s: %s, %0d failed checks", curTest + 1,
                   testName(curTest), (testErrors == 0) ? "passed" : "failed", testErrors);
          if (testErrors == 0)
            testsPassed++;
          else
            testsFailed++;
          testErrors = 0;
          curTest++;
        end
        4'h9: begin  // Internal clock toggles every ce cycle
          while (oddCycle) @(negedge clk);
          @(negedge clk);
          checkOddCycle(1'b1, oddCycle);
          @(negedge clk);
          checkOddCycle(1'b0, oddCycle);  // Next write lands on an even cycle
        end
        default: begin
          $display("Record %0d holds an unknown operation %0h", n - 1, op);
          noteError();
          running = 1'b0;
        end
      endcase
    end

    if (curTest != numTests) begin
      $display("The stimulus ended after %0d of %0d tests", curTest, numTests);
      totalErrors++;
    end
    $display("Tests passed: %0d, failed: %0d, failed checks: %0d",
             testsPassed, testsFailed, totalErrors);
    if (totalErrors == 0 && testsFailed == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- apuStimulus.mem
// Columns op_addr_data_count_expected. Ops 1 write, 2 status read, 3 irq check,
// 4 min/max window (data is min), 5 level set, 6 wait, 7 ce/mask, 8 test end, 9 even cycle
// Reset state
7_00_80_0000_0000
2_15_00_0000_0000
3_00_00_0000_0000
4_00_00_0001_0000
8_00_00_0000_0000
// Length status
1_15_07_0000_0000
1_03_08_0000_0000
1_07_08_0000_0000
1_0B_08_0000_0000
2_15_00_0000_0007
1_15_00_0000_0000
6_00_00_0001_0000
2_15_00_0000_0000
8_00_00_0000_0000
// Frame irq, 4-step mode
9_00_00_0000_0000
1_17_00_0000_0000
6_00_00_7485_0000
3_00_00_0000_0000
3_00_00_0000_0001
2_15_00_0000_0040
2_15_00_0000_0000
3_00_00_0000_0000
9_00_00_0000_0000
1_17_40_0000_0000
6_00_00_748B_0000
3_00_00_0000_0000
2_15_00_0000_0000
8_00_00_0000_0000
// Five-step length
1_15_01_0000_0000
1_00_10_0000_0000
1_03_18_0000_0000
2_15_00_0000_0001
9_00_00_0000_0000
1_17_80_0000_0000
2_15_00_0000_0001
6_00_00_91A1_0000
2_15_00_0000_0000
3_00_00_0000_0000
8_00_00_0000_0000
// Pulse window
7_00_81_0000_0000
1_00_F9_0000_0000
1_01_00_0000_0000
1_02_64_0000_0000
1_03_08_0000_0000
4_00_00_07D0_0009
7_00_80_0000_0000
4_00_00_07D0_0000
8_00_00_0000_0000
// Triangle levels
7_00_84_0000_0000
1_15_04_0000_0000
1_08_FF_0000_0000
1_0A_10_0000_0000
1_0B_08_0000_0000
9_00_00_0000_0000
1_17_80_0000_0000
5_00_00_03E8_FFFF
4_00_00_0258_001E
8_00_00_0000_0000
0_00_00_0000_0000

//--- all.f
apuRegPkg.sv
apuAudioPkg.sv
lengthCounter.sv
envelopeUnit.sv
squareChannel.sv
triangleChannel.sv
frameSequencer.sv
apuStatus.sv
audioMixer.sv
apuTop.sv
tbClock.sv
apuTb.sv
